/* design/hub75_bcm.sv */
`timescale 1ns/1ps
`include "hub75_config.svh"

module hub75_bcm
	import hub75_pkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  row_t   ctrl_row,
	input  logic   ctrl_go,
	output logic   ctrl_rdy,
	output plane_t shift_plane,
	output logic   shift_go,
	input  logic   shift_rdy,
	output plane_t blank_plane,
	output logic   blank_go,
	input  logic   blank_rdy,
	input  len_t   pre_latch_len,
	input  len_t   latch_len,
	input  len_t   post_latch_len,
	output row_t   hub75_addr,
	output logic   hub75_le,
	output logic   blank_req
);

	localparam plane_t last_plane = plane_t'(`HUB75_N_PLANES - 1);

	bcm_state_t state;
	plane_t plane;
	len_t cnt; // shared by pre, latch and post
	logic cnt_done;

	// a length of 0 still spends one cycle in the state
	assign cnt_done = (cnt <= 8'd1);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= bcm_idle;
			plane <= '0;
			cnt <= '0;
			shift_go <= 1'b0;
			blank_go <= 1'b0;
			blank_req <= 1'b0;
			hub75_addr <= '0;
			hub75_le <= 1'b0;
		end else begin
			shift_go <= 1'b0;
			blank_go <= 1'b0;
			cnt <= cnt - 1'b1;
			case (state)
				bcm_idle: begin
					if (ctrl_go) begin
						plane <= '0;
						shift_go <= 1'b1;
						state <= bcm_shift;
					end
				end
				bcm_shift: begin
					if (shift_rdy && !shift_go) begin // rdy is stale while go is out
						state <= bcm_wait_blank;
					end
				end
				bcm_wait_blank: begin
					if (blank_rdy) begin // previous plane done showing
						blank_req <= 1'b1;
						cnt <= pre_latch_len;
						state <= bcm_pre_latch;
					end
				end
				bcm_pre_latch: begin
					if (cnt_done) begin
						hub75_le <= 1'b1;
						hub75_addr <= ctrl_row; // new row with the latch
						cnt <= latch_len;
						state <= bcm_latch;
					end
				end
				bcm_latch: begin
					if (cnt_done) begin
						hub75_le <= 1'b0;
						cnt <= post_latch_len;
						state <= bcm_post_latch;
					end
				end
				bcm_post_latch: begin
					if (cnt_done) begin
						blank_req <= 1'b0;
						blank_go <= 1'b1; // show this plane
						state <= bcm_next;
					end
				end
				bcm_next: begin
					if (plane != last_plane) begin
						plane <= plane + 1'b1; // shift overlaps display
						shift_go <= 1'b1;
						state <= bcm_shift;
					end else if (blank_rdy && !blank_go) begin
						state <= bcm_idle; // last plane fully shown
					end
				end
				default: state <= bcm_idle;
			endcase
		end
	end

	assign ctrl_rdy = (state == bcm_idle);
	assign shift_plane = plane;
	assign blank_plane = plane;

endmodule

/* design/hub75_blanking.sv */
`timescale 1ns/1ps
`include "hub75_config.svh"

module hub75_blanking
	import hub75_pkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  plane_t ctrl_plane,
	input  logic   ctrl_go,
	output logic   ctrl_rdy,
	input  len_t   bit_len,
	input  logic   blank_req,
	output logic   hub75_blank
);

	// room for bit_len shifted by the top plane
	localparam int cnt_w = 8 + `HUB75_N_PLANES - 1;

	logic [cnt_w-1:0] cnt; // display cycles left

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cnt <= '0;
			hub75_blank <= 1'b1; // dark out of reset
		end else begin
			if (ctrl_go) begin
				cnt <= {{(cnt_w-8){1'b0}}, bit_len} << ctrl_plane; // weight 2^p
			end else if (cnt != '0) begin
				cnt <= cnt - 1'b1;
			end
			hub75_blank <= (cnt == '0) | blank_req;
		end
	end

	assign ctrl_rdy = (cnt == '0);

endmodule

/* design/hub75_cfg_regs.sv */
`timescale 1ns/1ps
`include "hub75_config.svh"

module hub75_cfg_regs
	import hub75_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      cfg_we,
	input  reg_addr_t cfg_addr,
	input  len_t      cfg_wdata,
	output len_t      pre_latch_len,
	output len_t      latch_len,
	output len_t      post_latch_len,
	output len_t      bit_len,
	output logic      run
);

	localparam reg_addr_t addr_pre = 3'd0;
	localparam reg_addr_t addr_latch = 3'd1;
	localparam reg_addr_t addr_post = 3'd2;
	localparam reg_addr_t addr_bit = 3'd3;
	localparam reg_addr_t addr_ctrl = 3'd4;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pre_latch_len <= len_t'(`HUB75_RST_PRE_LATCH);
			latch_len <= len_t'(`HUB75_RST_LATCH);
			post_latch_len <= len_t'(`HUB75_RST_POST_LATCH);
			bit_len <= len_t'(`HUB75_RST_BIT_LEN);
			run <= 1'b0; // panel stays dark until enabled
		end else if (cfg_we) begin
			case (cfg_addr)
				addr_pre: pre_latch_len <= cfg_wdata;
				addr_latch: latch_len <= cfg_wdata;
				addr_post: post_latch_len <= cfg_wdata;
				addr_bit: bit_len <= cfg_wdata;
				addr_ctrl: run <= cfg_wdata[0];
				default: ; // unmapped address dropped
			endcase
		end
	end

endmodule

/* design/hub75_framebuffer.sv */
`timescale 1ns/1ps
`include "hub75_config.svh"

module hub75_framebuffer
	import hub75_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  bank_t    wr_bank,
	input  row_t     wr_row,
	input  col_t     wr_col,
	input  pixel_t   wr_data,
	input  logic     wr_en,
	input  row_t     rd_row,
	input  col_t     rd_col,
	input  logic     rd_en,
	output rd_word_t rd_data,
	input  logic     frame_swap
);

	localparam int pix_w = `HUB75_N_CHANS * `HUB75_N_PLANES;

	// [buffer][bank][row][col]
	pixel_t mem [2][`HUB75_N_BANKS][`HUB75_N_ROWS][`HUB75_N_COLS];
	logic front; // buffer being scanned

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			front <= 1'b0;
		end else if (frame_swap) begin
			front <= ~front; // back becomes front
		end
	end

	// writer only ever touches the back buffer
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[~front][wr_bank][wr_row][wr_col] <= wr_data;
		end
	end

	// one read returns the same pixel of every bank
	always_ff @(posedge clk) begin
		if (rd_en) begin
			for (int b = 0; b < `HUB75_N_BANKS; b++) begin
				rd_data[b*pix_w +: pix_w] <= mem[front][b][rd_row][rd_col];
			end
		end
	end

endmodule

/* design/hub75_pkg.sv */
`include "hub75_config.svh"

package hub75_pkg;

	typedef logic [$clog2(`HUB75_N_ROWS)-1:0] row_t;
	typedef logic [$clog2(`HUB75_N_COLS)-1:0] col_t;
	typedef logic [$clog2(`HUB75_N_BANKS)-1:0] bank_t;
	typedef logic [$clog2(`HUB75_N_PLANES)-1:0] plane_t;
	typedef logic [`HUB75_N_CHANS*`HUB75_N_PLANES-1:0] pixel_t; // bit c*planes+p
	typedef logic [`HUB75_N_BANKS*`HUB75_N_CHANS*`HUB75_N_PLANES-1:0] rd_word_t;
	typedef logic [`HUB75_N_BANKS*`HUB75_N_CHANS-1:0] pad_data_t; // bank-major
	typedef logic [7:0] len_t;
	typedef logic [2:0] reg_addr_t;

	typedef enum logic [2:0] {
		bcm_idle,
		bcm_shift,
		bcm_wait_blank,
		bcm_pre_latch,
		bcm_latch,
		bcm_post_latch,
		bcm_next
	} bcm_state_t;

	typedef enum logic [1:0] {sh_idle, sh_read, sh_data, sh_clock} shift_state_t;

	typedef enum logic [1:0] {sc_idle, sc_row, sc_wait} scan_state_t;

endpackage

/* design/hub75_scan.sv */
`timescale 1ns/1ps
`include "hub75_config.svh"

module hub75_scan
	import hub75_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic run,
	input  logic frame_swap,
	output logic frame_rdy,
	output logic fb_swap,
	output row_t bcm_row,
	output logic bcm_go,
	input  logic bcm_rdy
);

	localparam row_t last_row = row_t'(`HUB75_N_ROWS - 1);

	scan_state_t state;
	row_t row;
	logic pending; // swap requested, not yet applied
	logic frame_end;
	logic release_swap;

	always_comb begin
		// idle counts as frame end so a swap goes through while stopped
		frame_end = (state == sc_idle) |
			((state == sc_wait) & bcm_rdy & (row == last_row));
		release_swap = pending & frame_end;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= sc_idle;
			row <= '0;
			pending <= 1'b0;
			fb_swap <= 1'b0;
			bcm_go <= 1'b0;
		end else begin
			pending <= frame_swap | (pending & ~release_swap);
			fb_swap <= release_swap; // same cycle as frame_rdy rising
			bcm_go <= 1'b0;
			case (state)
				sc_idle: begin
					if (run && !pending) begin // new frame
						bcm_go <= 1'b1;
						state <= sc_row;
					end
				end
				sc_row: state <= sc_wait; // let bcm drop rdy
				sc_wait: begin
					if (bcm_rdy) begin
						if (row == last_row) begin
							row <= '0;
							state <= sc_idle;
						end else begin
							row <= row + 1'b1; // linear scan
							bcm_go <= 1'b1;
							state <= sc_row;
						end
					end
				end
				default: state <= sc_idle;
			endcase
		end
	end

	assign frame_rdy = ~pending;
	assign bcm_row = row;

endmodule

/* design/hub75_shift.sv */
`timescale 1ns/1ps
`include "hub75_config.svh"

module hub75_shift
	import hub75_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  row_t      ctrl_row,
	input  plane_t    ctrl_plane,
	input  logic      ctrl_go,
	output logic      ctrl_rdy,
	output row_t      ram_row,
	output col_t      ram_col,
	output logic      ram_rden,
	input  rd_word_t  ram_data,
	output pad_data_t hub75_data,
	output logic      hub75_clk
);

	localparam int pix_w = `HUB75_N_CHANS * `HUB75_N_PLANES;
	localparam col_t last_col = col_t'(`HUB75_N_COLS - 1);

	shift_state_t state;
	col_t col;
	pad_data_t pick; // one plane of every bank and channel

	always_comb begin
		for (int b = 0; b < `HUB75_N_BANKS; b++) begin
			for (int c = 0; c < `HUB75_N_CHANS; c++) begin
				pick[b*`HUB75_N_CHANS + c] =
					ram_data[b*pix_w + c*`HUB75_N_PLANES + int'(ctrl_plane)];
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= sh_idle;
			col <= '0;
			hub75_data <= '0;
			hub75_clk <= 1'b0;
		end else begin
			hub75_clk <= (state == sh_clock); // one cycle after data
			case (state)
				sh_idle: begin
					if (ctrl_go) begin
						col <= '0;
						state <= sh_read;
					end
				end
				sh_read: state <= sh_data; // word back next cycle
				sh_data: begin
					hub75_data <= pick;
					state <= sh_clock;
				end
				sh_clock: begin
					if (col == last_col) begin
						state <= sh_idle;
					end else begin
						col <= col + 1'b1;
						state <= sh_read;
					end
				end
				default: state <= sh_idle;
			endcase
		end
	end

	assign ctrl_rdy = (state == sh_idle);
	assign ram_row = ctrl_row;
	assign ram_col = col;
	assign ram_rden = (state == sh_read);

endmodule

/* design/hub75_top.sv */
`timescale 1ns/1ps
`include "hub75_config.svh"

module hub75_top
	import hub75_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	output row_t      hub75_addr,
	output pad_data_t hub75_data,
	output logic      hub75_clk,
	output logic      hub75_le,
	output logic      hub75_blank,
	input  bank_t     fbw_bank,
	input  row_t      fbw_row,
	input  col_t      fbw_col,
	input  pixel_t    fbw_data,
	input  logic      fbw_wren,
	input  logic      frame_swap,
	output logic      frame_rdy,
	input  logic      cfg_we,
	input  reg_addr_t cfg_addr,
	input  len_t      cfg_wdata
);

	// config
	len_t pre_latch_len, latch_len, post_latch_len, bit_len;
	logic run;

	// frame buffer read side
	row_t rd_row;
	col_t rd_col;
	logic rd_en;
	rd_word_t rd_data;
	logic fb_swap;

	// scan / bcm / shift / blanking strobes
	row_t bcm_row;
	logic bcm_go, bcm_rdy;
	plane_t shift_plane, blank_plane;
	logic shift_go, shift_rdy;
	logic blank_go, blank_rdy, blank_req;

	hub75_framebuffer i_fb (
		.clk(clk),
		.rst(rst),
		.wr_bank(fbw_bank), // back buffer only
		.wr_row(fbw_row),
		.wr_col(fbw_col),
		.wr_data(fbw_data),
		.wr_en(fbw_wren),
		.rd_row(rd_row), // from shifter
		.rd_col(rd_col),
		.rd_en(rd_en),
		.rd_data(rd_data),
		.frame_swap(fb_swap) // from scan, at frame end
	);

	hub75_scan i_scan (
		.clk(clk),
		.rst(rst),
		.run(run),
		.frame_swap(frame_swap),
		.frame_rdy(frame_rdy),
		.fb_swap(fb_swap),
		.bcm_row(bcm_row),
		.bcm_go(bcm_go),
		.bcm_rdy(bcm_rdy)
	);

	hub75_cfg_regs i_cfg (
		.clk(clk),
		.rst(rst),
		.cfg_we(cfg_we),
		.cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata),
		.pre_latch_len(pre_latch_len),
		.latch_len(latch_len),
		.post_latch_len(post_latch_len),
		.bit_len(bit_len),
		.run(run)
	);

	hub75_bcm i_bcm (
		.clk(clk),
		.rst(rst),
		.ctrl_row(bcm_row),
		.ctrl_go(bcm_go),
		.ctrl_rdy(bcm_rdy),
		.shift_plane(shift_plane),
		.shift_go(shift_go),
		.shift_rdy(shift_rdy),
		.blank_plane(blank_plane),
		.blank_go(blank_go),
		.blank_rdy(blank_rdy),
		.pre_latch_len(pre_latch_len),
		.latch_len(latch_len),
		.post_latch_len(post_latch_len),
		.hub75_addr(hub75_addr), // pad
		.hub75_le(hub75_le), // pad
		.blank_req(blank_req)
	);

	hub75_shift i_shift (
		.clk(clk),
		.rst(rst),
		.ctrl_row(bcm_row), // same row the bcm latches
		.ctrl_plane(shift_plane),
		.ctrl_go(shift_go),
		.ctrl_rdy(shift_rdy),
		.ram_row(rd_row),
		.ram_col(rd_col),
		.ram_rden(rd_en),
		.ram_data(rd_data),
		.hub75_data(hub75_data), // pad
		.hub75_clk(hub75_clk) // pad
	);

	hub75_blanking i_blank (
		.clk(clk),
		.rst(rst),
		.ctrl_plane(blank_plane),
		.ctrl_go(blank_go),
		.ctrl_rdy(blank_rdy),
		.bit_len(bit_len),
		.blank_req(blank_req),
		.hub75_blank(hub75_blank) // pad
	);

endmodule

/* include/hub75_config.svh */
`ifndef HUB75_CONFIG_SVH
`define HUB75_CONFIG_SVH

// panel geometry
`define HUB75_N_BANKS 2
`define HUB75_N_ROWS 4 // power of two only
`define HUB75_N_COLS 8
`define HUB75_N_CHANS 3
`define HUB75_N_PLANES 4

// register reset values in clk cycles
`define HUB75_RST_PRE_LATCH 2
`define HUB75_RST_LATCH 2
`define HUB75_RST_POST_LATCH 2
`define HUB75_RST_BIT_LEN 4 // plane 0 display time

`endif

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal -f src.f --top-module hub75_tb -o hub75_sim \
	|| { echo "verilator build failed"; exit 1; }
out=$(./obj_dir/hub75_sim)
echo "$out"
echo "$out" | grep -qx "SIMULATION PASSED" && exit 0 || exit 1

/* src.f */
+incdir+include
design/hub75_pkg.sv
design/hub75_framebuffer.sv
design/hub75_scan.sv
design/hub75_cfg_regs.sv
design/hub75_bcm.sv
design/hub75_shift.sv
design/hub75_blanking.sv
design/hub75_top.sv
testbench/hub75_tb.sv

/* testbench/hub75_tb.sv */
`timescale 1ns/1ps
`include "hub75_config.svh"

module hub75_tb
	import hub75_pkg::*;
;

	localparam int n_planes = `HUB75_N_PLANES;
	localparam int n_rows = `HUB75_N_ROWS;
	localparam int n_cols = `HUB75_N_COLS;
	localparam int frame_latches = n_planes * n_rows; // one latch per plane per row

	logic clk = 1'b0;
	logic rst;
	row_t hub75_addr;
	pad_data_t hub75_data;
	logic hub75_clk, hub75_le, hub75_blank;
	bank_t fbw_bank;
	row_t fbw_row;
	col_t fbw_col;
	pixel_t fbw_data;
	logic fbw_wren, frame_swap, frame_rdy;
	logic cfg_we;
	reg_addr_t cfg_addr;
	len_t cfg_wdata;

	pixel_t frame_model [2][`HUB75_N_BANKS][n_rows][n_cols]; // [buffer][bank][row][col]
	int front_sel = 0;
	logic [15:0] lfsr = 16'd87;
	int latch_len_exp, bit_len_exp;
	int cat_err [7]; // idle, shift, latch, display, row, swap, stop
	int err_total = 0;
	int tests_pass = 0;
	int tests_fail = 0;
	int col_cnt, le_len, low_len, latch_cnt, disp_cnt;
	logic frame_rdy_q, le_q, blank_q;

	hub75_top i_hub75_top (.*);

	always #10 clk = ~clk;

	function automatic logic random_bit();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]; // x^16+x^14+x^13+x^11+1
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	// plane p of channel c sits at pixel bit c*planes+p and pads go bank-major
	function automatic pad_data_t expected_data(int row, int col, int plane);
		pad_data_t d;
		for (int b = 0; b < `HUB75_N_BANKS; b++) begin
			for (int c = 0; c < `HUB75_N_CHANS; c++) begin
				d[b*`HUB75_N_CHANS + c] = frame_model[front_sel][b][row][col][c*n_planes + plane];
			end
		end
		return d;
	endfunction

	task automatic report_error(input int cat, input string msg);
		$display("** Error at %0t ns: %s", $time, msg);
		cat_err[cat]++;
		err_total++;
	endtask

	task automatic note_timeout(input int cat, input string what);
		$display("timeout: %s did not happen in time", what);
		cat_err[cat]++;
		err_total++;
	endtask

	task automatic finish_test(input string name, input int n);
		if (n == 0) begin
			tests_pass++;
			$display("test %s: pass", name);
		end else begin
			tests_fail++;
			$display("test %s: fail with %0d errors", name, n);
		end
	endtask

	task automatic write_reg(input int addr, input int data);
		@(negedge clk);
		cfg_we = 1'b1;
		cfg_addr = reg_addr_t'(addr);
		cfg_wdata = len_t'(data);
		@(negedge clk);
		cfg_we = 1'b0;
	endtask

	task automatic load_random_frame();
		pixel_t pix;
		for (int b = 0; b < `HUB75_N_BANKS; b++) begin
			for (int r = 0; r < n_rows; r++) begin
				for (int c = 0; c < n_cols; c++) begin
					for (int i = 0; i < $bits(pixel_t); i++) begin
						pix[i] = random_bit(); // one lfsr step per bit
					end
					@(negedge clk);
					fbw_bank = bank_t'(b);
					fbw_row = row_t'(r);
					fbw_col = col_t'(c);
					fbw_data = pix;
					fbw_wren = 1'b1;
					frame_model[1 - front_sel][b][r][c] = pix; // mirror of back buffer
					@(negedge clk);
					fbw_wren = 1'b0;
				end
			end
		end
	endtask

	task automatic pulse_frame_swap();
		@(negedge clk);
		frame_swap = 1'b1;
		@(negedge clk);
		frame_swap = 1'b0;
	endtask

	task automatic await_frame_rdy(input logic level, input int limit);
		int n;
		n = 0;
		while (frame_rdy !== level && n < limit) begin // checked before first wait
			@(negedge clk);
			n++;
		end
		if (frame_rdy !== level) note_timeout(5, $sformatf("frame_rdy level %0d", level));
	endtask

	task automatic wait_displays(input int target, input int limit, input int cat);
		int n;
		n = 0;
		while (disp_cnt < target && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (disp_cnt < target) note_timeout(cat, $sformatf("display count %0d", target));
	endtask

	task automatic seek_latch_phase(input int phase, input int limit);
		int n;
		n = 0;
		while (latch_cnt % frame_latches != phase && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (latch_cnt % frame_latches != phase) note_timeout(6, "mid-frame latch");
	endtask

	// pad monitor samples everything mid-cycle
	always @(negedge clk) begin : pad_monitor
		int row;
		int plane;
		if (rst) begin
			frame_rdy_q = 1'b1;
			le_q = 1'b0;
			blank_q = 1'b1;
			col_cnt = 0;
			le_len = 0;
			low_len = 0;
			latch_cnt = 0;
			disp_cnt = 0;
		end else begin
			row = (latch_cnt / n_planes) % n_rows; // row and plane of the next latch
			plane = latch_cnt % n_planes;
			if (frame_rdy && !frame_rdy_q) begin
				front_sel = 1 - front_sel; // model swap with frame_rdy
				assert (latch_cnt % frame_latches == 0)
					else report_error(5, "frame_rdy rose in mid frame");
			end
			if (hub75_clk) begin
				assert (col_cnt < n_cols) else report_error(1, "too many shift clocks");
				assert (hub75_data == expected_data(row, col_cnt % n_cols, plane))
					else report_error(1, $sformatf("data %h row %0d col %0d plane %0d",
						hub75_data, row, col_cnt, plane));
				col_cnt++;
			end
			if (hub75_le) begin
				if (!le_q) begin
					assert (col_cnt == n_cols)
						else report_error(2, $sformatf("%0d clocks before latch", col_cnt));
					assert (hub75_addr == row_t'(row))
						else report_error(4, $sformatf("addr %0d, expected %0d", hub75_addr, row));
					col_cnt = 0;
				end
				le_len++;
			end else if (le_q) begin
				assert (le_len == latch_len_exp)
					else report_error(2, $sformatf("latch %0d cycles, expected %0d",
						le_len, latch_len_exp));
				le_len = 0;
				latch_cnt++;
			end
			if (!hub75_blank) begin
				low_len++;
			end else if (!blank_q) begin
				assert (low_len == (bit_len_exp << ((latch_cnt - 1) % n_planes)))
					else report_error(3, $sformatf("display %0d cycles", low_len));
				low_len = 0;
				disp_cnt++;
			end
			frame_rdy_q = frame_rdy;
			le_q = hub75_le;
			blank_q = hub75_blank;
		end
	end

	assert property (@(negedge clk) disable iff (rst) hub75_le |-> hub75_blank)
		else report_error(2, "hub75_blank low during latch");

	initial begin
		int target;
		rst = 1'b1;
		fbw_bank = '0;
		fbw_row = '0;
		fbw_col = '0;
		fbw_data = '0;
		fbw_wren = 1'b0;
		frame_swap = 1'b0;
		cfg_we = 1'b0;
		cfg_addr = '0;
		cfg_wdata = '0;
		latch_len_exp = `HUB75_RST_LATCH;
		bit_len_exp = `HUB75_RST_BIT_LEN;
		repeat (2) @(negedge clk);
		rst = 1'b0;

		for (int i = 0; i < 200; i++) begin // run is 0 out of reset
			@(negedge clk);
			assert (!hub75_clk && !hub75_le && hub75_blank)
				else report_error(0, "panel active with run low");
		end
		finish_test("reset idle", cat_err[0]);

		load_random_frame(); // first frame while stopped
		pulse_frame_swap();
		await_frame_rdy(1'b0, 10);
		await_frame_rdy(1'b1, 10);
		write_reg(0, 3);
		write_reg(1, 2);
		write_reg(2, 1);
		write_reg(3, 3);
		latch_len_exp = 2;
		bit_len_exp = 3;
		write_reg(4, 1);
		wait_displays(2 * frame_latches, 6000, 1);
		finish_test("shift data", cat_err[1]);
		finish_test("latch", cat_err[2]);
		finish_test("display weighting", cat_err[3]);
		finish_test("row order", cat_err[4]);
		cat_err[1] = 0;

		load_random_frame(); // written while the old frame scans
		pulse_frame_swap();
		await_frame_rdy(1'b0, 10);
		await_frame_rdy(1'b1, 3000);
		target = latch_cnt + frame_latches;
		wait_displays(target, 3000, 5);
		finish_test("frame swap", cat_err[5] + cat_err[1]);
		cat_err[1] = 0;
		cat_err[2] = 0;
		cat_err[3] = 0;
		cat_err[4] = 0;

		seek_latch_phase(4, 3000);
		write_reg(4, 0);
		target = (latch_cnt / frame_latches + 1) * frame_latches; // next frame end
		wait_displays(target, 3000, 6);
		for (int i = 0; i < 300; i++) begin
			@(negedge clk);
			assert (!hub75_clk) else report_error(6, "shift clock after stop");
		end
		assert (latch_cnt == target && hub75_blank)
			else report_error(6, $sformatf("stopped at latch %0d", latch_cnt));
		finish_test("run stop", cat_err[6]);

		write_reg(1, 5); // new lengths while stopped
		write_reg(3, 2);
		latch_len_exp = 5;
		bit_len_exp = 2;
		write_reg(4, 1);
		target = latch_cnt + frame_latches;
		wait_displays(target, 3000, 2);
		finish_test("latch after reconfig", cat_err[1] + cat_err[2] + cat_err[3] + cat_err[4]);

		$display("tests passed %0d, failed %0d, errors %0d", tests_pass, tests_fail, err_total);
		if (err_total == 0 && tests_fail == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule
